// ==== verilog/pea_macros.svh ====
`ifndef PEA_MACROS_SVH
`define PEA_MACROS_SVH

// Array geometry
`define PEA_ROWS 4
`define PEA_COLS 4

// Datapath widths
`define PEA_DATA_W    32
`define PEA_CONST_W   8
`define PEA_ACC_W     8
`define PEA_ROW_SEL_W 2

`endif

// ==== verilog/pea_pkg.sv ====
`include "pea_macros.svh"

package pea_pkg;

  //////////////////////////////////////////////////
  // Operand sources and operations
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    SRC_STREAM = 3'd0,
    SRC_CONST  = 3'd1,
    SRC_NORTH  = 3'd2,
    SRC_WEST   = 3'd3,
    SRC_EAST   = 3'd4,
    SRC_SOUTH  = 3'd5,
    SRC_ZERO   = 3'd6
  } pe_src_e;

  // Multiply keeps the low word of the product
  typedef enum logic [1:0] {
    OP_ADD    = 2'd0,
    OP_SUB    = 2'd1,
    OP_MUL    = 2'd2,
    OP_PASS_A = 2'd3
  } pe_op_e;

  //////////////////////////////////////////////////
  // Per-PE configuration and stream beat
  //////////////////////////////////////////////////

  typedef struct packed {
    pe_src_e                 src_a;
    pe_src_e                 src_b;
    pe_op_e                  op;
    logic                    acc_en;
    logic [`PEA_CONST_W-1:0] constant;
    logic [`PEA_ACC_W-1:0]   acc_count;
  } pe_cfg_t;

  typedef struct packed {
    logic                   valid;
    logic [`PEA_DATA_W-1:0] data;
  } stream_beat_t;

endpackage

// ==== verilog/pe_acc_counter.sv ====
`timescale 1ns/1ps
`include "pea_macros.svh"

module pe_acc_counter (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  fire_i,
  input  logic [`PEA_ACC_W-1:0] acc_count_i,
  output logic                  last_o
);

  logic [`PEA_ACC_W-1:0] cnt_q;
  logic [`PEA_ACC_W-1:0] final_idx;

  // Zero count behaves like a count of one
  assign final_idx = (acc_count_i == '0) ? '0 : acc_count_i - 1'b1;

  // Greater-or-equal also closes a group if the count shrinks mid-run
  assign last_o = fire_i & (cnt_q >= final_idx);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (fire_i) begin
      if (last_o) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

// ==== verilog/pe.sv ====
`timescale 1ns/1ps
`include "pea_macros.svh"

module pe (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  pea_pkg::pe_cfg_t      cfg_i,
  input  pea_pkg::stream_beat_t stream_i,
  input  pea_pkg::stream_beat_t north_i,
  input  pea_pkg::stream_beat_t west_i,
  input  pea_pkg::stream_beat_t east_i,
  input  pea_pkg::stream_beat_t south_i,
  output pea_pkg::stream_beat_t out_o
);

  import pea_pkg::*;

  stream_beat_t [7:0]     src_vec;
  stream_beat_t           op_a;
  stream_beat_t           op_b;
  logic [`PEA_DATA_W-1:0] alu_res;
  logic [`PEA_DATA_W-1:0] acc_q;
  logic [`PEA_DATA_W-1:0] acc_sum;
  logic                   fire;
  logic                   acc_fire;
  logic                   acc_last;
  logic                   emit;
  logic                   valid_q;
  logic [`PEA_DATA_W-1:0] data_q;

  //////////////////////////////////////////////////
  // Operand select
  //////////////////////////////////////////////////

  assign src_vec[SRC_STREAM] = stream_i;
  assign src_vec[SRC_CONST]  = '{valid: 1'b1,
                                 data: {{(`PEA_DATA_W-`PEA_CONST_W){1'b0}}, cfg_i.constant}};
  assign src_vec[SRC_NORTH]  = north_i;
  assign src_vec[SRC_WEST]   = west_i;
  assign src_vec[SRC_EAST]   = east_i;
  assign src_vec[SRC_SOUTH]  = south_i;
  assign src_vec[SRC_ZERO]   = '{valid: 1'b1, data: '0};
  // Unused code never fires
  assign src_vec[7]          = '0;

  assign op_a = src_vec[cfg_i.src_a];
  assign op_b = src_vec[cfg_i.src_b];
  assign fire = op_a.valid & op_b.valid;

  //////////////////////////////////////////////////
  // ALU and accumulate
  //////////////////////////////////////////////////

  always_comb begin
    case (cfg_i.op)
      OP_ADD:  alu_res = op_a.data + op_b.data;
      OP_SUB:  alu_res = op_a.data - op_b.data;
      OP_MUL:  alu_res = op_a.data * op_b.data;
      default: alu_res = op_a.data;
    endcase
  end

  assign acc_fire = fire & cfg_i.acc_en;
  assign acc_sum  = acc_q + alu_res;
  assign emit     = cfg_i.acc_en ? acc_last : fire;

  pe_acc_counter i_acc_counter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .fire_i      (acc_fire),
    .acc_count_i (cfg_i.acc_count),
    .last_o      (acc_last)
  );

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= emit;
      if (acc_fire) begin
        // Sum restarts once a group is emitted
        acc_q <= acc_last ? '0 : acc_sum;
      end
    end
  end

  // Result holds between emits
  always_ff @(posedge clk_i) begin
    if (emit) begin
      data_q <= cfg_i.acc_en ? acc_sum : alu_res;
    end
  end

  assign out_o = '{valid: valid_q, data: data_q};

endmodule

// ==== verilog/pea_array.sv ====
`timescale 1ns/1ps
`include "pea_macros.svh"

module pea_array (
  input  logic                                                 clk_i,
  input  logic                                                 rst_n_i,
  input  pea_pkg::pe_cfg_t      [`PEA_ROWS-1:0][`PEA_COLS-1:0] cfg_i,
  input  pea_pkg::stream_beat_t                                stream_i,
  output pea_pkg::stream_beat_t [`PEA_ROWS-1:0][`PEA_COLS-1:0] pe_out_o,
  output logic                                                 ready_o
);

  import pea_pkg::*;

  // Rows that see the input stream
  localparam int STREAM_ROWS = 2;

  // Tie-off for grid edges and rows without a stream
  localparam stream_beat_t EDGE_BEAT = '{valid: 1'b1, data: '0};

  logic [`PEA_ROWS*`PEA_COLS-1:0] valid_vec;

  for (genvar r = 0; r < `PEA_ROWS; r++) begin : g_row
    for (genvar c = 0; c < `PEA_COLS; c++) begin : g_col
      stream_beat_t stream_b;
      stream_beat_t north_b;
      stream_beat_t west_b;
      stream_beat_t east_b;
      stream_beat_t south_b;

      assign stream_b = (r < STREAM_ROWS) ? stream_i : EDGE_BEAT;

      //////////////////////////////////////////////////
      // Neighbour wiring
      //////////////////////////////////////////////////
      if (r == 0) begin : g_n_edge
        assign north_b = EDGE_BEAT;
      end else begin : g_n
        assign north_b = pe_out_o[r-1][c];
      end

      if (c == 0) begin : g_w_edge
        assign west_b = EDGE_BEAT;
      end else begin : g_w
        assign west_b = pe_out_o[r][c-1];
      end

      if (c == `PEA_COLS-1) begin : g_e_edge
        assign east_b = EDGE_BEAT;
      end else begin : g_e
        assign east_b = pe_out_o[r][c+1];
      end

      if (r == `PEA_ROWS-1) begin : g_s_edge
        assign south_b = EDGE_BEAT;
      end else begin : g_s
        assign south_b = pe_out_o[r+1][c];
      end

      pe i_pe (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .cfg_i    (cfg_i[r][c]),
        .stream_i (stream_b),
        .north_i  (north_b),
        .west_i   (west_b),
        .east_i   (east_b),
        .south_i  (south_b),
        .out_o    (pe_out_o[r][c])
      );

      assign valid_vec[r*`PEA_COLS+c] = pe_out_o[r][c].valid;
    end
  end

  assign ready_o = &valid_vec;

endmodule

// ==== verilog/pea.sv ====
`timescale 1ns/1ps
`include "pea_macros.svh"

module pea (
  input  logic                                                 clk_i,
  input  logic                                                 rst_n_i,
  input  pea_pkg::pe_cfg_t      [`PEA_ROWS-1:0][`PEA_COLS-1:0] cfg_i,
  input  logic [`PEA_COLS-1:0][`PEA_ROW_SEL_W-1:0]             row_sel_i,
  input  pea_pkg::stream_beat_t                                stream_i,
  output pea_pkg::stream_beat_t [`PEA_COLS-1:0]                stream_o,
  output logic                                                 ready_o
);

  import pea_pkg::*;

  logic                                        in_valid_q;
  logic [`PEA_DATA_W-1:0]                      in_data_q;
  stream_beat_t                                in_beat;
  stream_beat_t [`PEA_ROWS-1:0][`PEA_COLS-1:0] pe_out;

  //////////////////////////////////////////////////
  // Input register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_valid_q <= 1'b0;
    end else begin
      in_valid_q <= stream_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    in_data_q <= stream_i.data;
  end

  assign in_beat = '{valid: in_valid_q, data: in_data_q};

  pea_array i_array (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .cfg_i    (cfg_i),
    .stream_i (in_beat),
    .pe_out_o (pe_out),
    .ready_o  (ready_o)
  );

  // One row per column drives the output stream
  always_comb begin
    for (int c = 0; c < `PEA_COLS; c++) begin
      stream_o[c] = pe_out[row_sel_i[c]][c];
    end
  end

endmodule

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release just after an edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

// ==== sim/tb_pea.sv ====
`timescale 1ns/1ps
`include "pea_macros.svh"

module tb_pea;

  import pea_pkg::*;

  localparam int MAX_CYCLES = 2000;
  localparam int IN_LAT     = 2;
  localparam int NUM_BEATS  = 20;
  localparam logic [`PEA_ACC_W-1:0] ACC_K = 5;

  typedef struct packed {
    int unsigned            due;
    logic [`PEA_DATA_W-1:0] data;
  } exp_beat_t;

  logic                                        clk;
  logic                                        rst_n;
  pe_cfg_t      [`PEA_ROWS-1:0][`PEA_COLS-1:0] cfg;
  logic [`PEA_COLS-1:0][`PEA_ROW_SEL_W-1:0]    row_sel;
  stream_beat_t                                stream;
  stream_beat_t [`PEA_COLS-1:0]                dut_out;
  logic                                        ready;

  exp_beat_t            exp_q [`PEA_COLS][$];
  logic [`PEA_COLS-1:0] chk_en;
  int unsigned          cyc = 0;
  int                   err_cnt;
  int                   chk_cnt;
  int                   test_cnt;

  tb_clk_gen #(.PERIOD_NS(8), .RST_CYCLES(8)) i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  pea i_dut (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .cfg_i     (cfg),
    .row_sel_i (row_sel),
    .stream_i  (stream),
    .stream_o  (dut_out),
    .ready_o   (ready)
  );

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic logic [`PEA_DATA_W-1:0] ref_op(input pe_op_e op,
      input logic [`PEA_DATA_W-1:0] a, input logic [`PEA_DATA_W-1:0] b);
    logic [2*`PEA_DATA_W-1:0] prod;
    prod = {{`PEA_DATA_W{1'b0}}, a} * {{`PEA_DATA_W{1'b0}}, b};
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_MUL:  return prod[`PEA_DATA_W-1:0];
      default: return a;
    endcase
  endfunction

  function automatic logic [`PEA_DATA_W-1:0] zext(input logic [`PEA_CONST_W-1:0] k);
    return {{(`PEA_DATA_W-`PEA_CONST_W){1'b0}}, k};
  endfunction

  function automatic logic [`PEA_CONST_W-1:0] rand_const();
    int unsigned r;
    r = $urandom_range(1, (1 << `PEA_CONST_W) - 1);
    return r[`PEA_CONST_W-1:0];
  endfunction

  function automatic int pending_beats();
    int n;
    n = 0;
    for (int c = 0; c < `PEA_COLS; c++) begin
      n += exp_q[c].size();
    end
    return n;
  endfunction

  //////////////////////////////////////////////////
  // Checks, cycle count and compare
  //////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [`PEA_DATA_W-1:0] exp_v,
                           input logic [`PEA_DATA_W-1:0] act_v);
    chk_cnt++;
    if (act_v !== exp_v) begin
      err_cnt++;
      $display("[FAIL] %s: expected 0x%08h, got 0x%08h at cycle %0d", name, exp_v, act_v, cyc);
    end
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc == MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  // Beats must land exactly on their due cycle, and nowhere else
  always @(negedge clk) begin
    exp_beat_t e;
    if (rst_n) begin
      for (int c = 0; c < `PEA_COLS; c++) begin
        if (chk_en[c]) begin
          if (exp_q[c].size() > 0 && exp_q[c][0].due == cyc) begin
            e = exp_q[c].pop_front();
            check_val($sformatf("stream_o[%0d].valid", c), 32'd1, {31'b0, dut_out[c].valid});
            check_val($sformatf("stream_o[%0d].data", c), e.data, dut_out[c].data);
          end else begin
            check_val($sformatf("stream_o[%0d].valid", c), 32'd0, {31'b0, dut_out[c].valid});
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic drive_beat(input logic [`PEA_DATA_W-1:0] d);
    stream = '{valid: 1'b1, data: d};
    next_cycle();
    stream.valid = 1'b0;
  endtask

  task automatic idle_gap();
    if ($urandom_range(0, 3) == 0) begin
      next_cycle();
    end
  endtask

  task automatic drain_expected();
    while (pending_beats() != 0) begin
      next_cycle();
    end
    repeat (3) next_cycle();
  endtask

  task automatic check_outputs_idle();
    for (int c = 0; c < `PEA_COLS; c++) begin
      check_val($sformatf("stream_o[%0d].valid", c), 32'd0, {31'b0, dut_out[c].valid});
    end
    check_val("ready_o", 32'd0, {31'b0, ready});
  endtask

  task automatic report_test(input string name, input int err_start);
    test_cnt++;
    if (err_cnt == err_start) begin
      $display("Test %0d %s: ok", test_cnt, name);
    end else begin
      $display("Test %0d %s: %0d errors", test_cnt, name, err_cnt - err_start);
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_reset();
    int err_start;
    err_start = err_cnt;
    next_cycle();
    repeat (3) begin
      @(negedge clk);
      check_outputs_idle();
    end
    wait (rst_n === 1'b1);
    next_cycle();
    repeat (5) begin
      @(negedge clk);
      check_outputs_idle();
    end
    next_cycle();
    report_test("reset", err_start);
  endtask

  // Column c runs operation c on stream and constant
  task automatic test_single_ops();
    logic [`PEA_CONST_W-1:0] k [`PEA_COLS];
    logic [`PEA_DATA_W-1:0]  d;
    int                      err_start;
    err_start = err_cnt;
    cfg = '0;
    row_sel = '0;
    for (int c = 0; c < `PEA_COLS; c++) begin
      k[c] = rand_const();
      cfg[0][c] = '{src_a: SRC_STREAM, src_b: SRC_CONST, op: pe_op_e'(c),
                    acc_en: 1'b0, constant: k[c], acc_count: '0};
    end
    chk_en = '1;
    for (int i = 0; i < NUM_BEATS; i++) begin
      idle_gap();
      d = $urandom();
      for (int c = 0; c < `PEA_COLS; c++) begin
        exp_q[c].push_back(exp_beat_t'{due: cyc + IN_LAT,
                                       data: ref_op(pe_op_e'(c), d, zext(k[c]))});
      end
      drive_beat(d);
    end
    drain_expected();
    chk_en = '0;
    report_test("single-PE operations", err_start);
  endtask

  task automatic test_chain();
    logic [`PEA_CONST_W-1:0] k0;
    logic [`PEA_CONST_W-1:0] k1;
    logic [`PEA_DATA_W-1:0]  d;
    int                      err_start;
    err_start = err_cnt;
    k0 = rand_const();
    k1 = rand_const();
    cfg = '0;
    cfg[0][0] = '{src_a: SRC_STREAM, src_b: SRC_CONST, op: OP_ADD,
                  acc_en: 1'b0, constant: k0, acc_count: '0};
    cfg[1][0] = '{src_a: SRC_NORTH, src_b: SRC_CONST, op: OP_SUB,
                  acc_en: 1'b0, constant: k1, acc_count: '0};
    row_sel = '0;
    row_sel[0] = 2'd1;
    chk_en = 4'b0001;
    for (int i = 0; i < NUM_BEATS; i++) begin
      idle_gap();
      d = $urandom();
      // One extra hop through the north link
      exp_q[0].push_back(exp_beat_t'{due: cyc + IN_LAT + 1,
                                     data: ref_op(OP_SUB, ref_op(OP_ADD, d, zext(k0)),
                                                  zext(k1))});
      drive_beat(d);
    end
    drain_expected();
    chk_en = '0;
    report_test("neighbour chaining", err_start);
  endtask

  task automatic test_accumulate();
    logic [`PEA_DATA_W-1:0] d;
    logic [`PEA_DATA_W-1:0] sum;
    int                     n;
    int                     err_start;
    err_start = err_cnt;
    cfg = '0;
    cfg[0][1] = '{src_a: SRC_STREAM, src_b: SRC_ZERO, op: OP_ADD,
                  acc_en: 1'b1, constant: '0, acc_count: ACC_K};
    row_sel = '0;
    chk_en = 4'b0010;
    sum = '0;
    n = 0;
    for (int i = 0; i < NUM_BEATS; i++) begin
      idle_gap();
      d = $urandom();
      sum = sum + ref_op(OP_ADD, d, '0);
      n++;
      if (n == int'(ACC_K)) begin
        exp_q[1].push_back(exp_beat_t'{due: cyc + IN_LAT, data: sum});
        sum = '0;
        n = 0;
      end
      drive_beat(d);
    end
    drain_expected();
    chk_en = '0;
    report_test("accumulation", err_start);
  endtask

  task automatic test_select_ready();
    logic [`PEA_CONST_W-1:0] kmat [`PEA_ROWS][`PEA_COLS];
    logic [`PEA_DATA_W-1:0]  k_ext;
    pe_op_e                  op;
    int                      err_start;
    err_start = err_cnt;
    cfg = '0;
    for (int r = 0; r < `PEA_ROWS; r++) begin
      for (int c = 0; c < `PEA_COLS; c++) begin
        kmat[r][c] = rand_const();
        cfg[r][c] = '{src_a: SRC_CONST, src_b: SRC_CONST, op: pe_op_e'((r + c) % 4),
                      acc_en: 1'b0, constant: kmat[r][c], acc_count: '0};
      end
    end
    next_cycle();
    next_cycle();
    for (int sel = 0; sel < `PEA_ROWS; sel++) begin
      for (int c = 0; c < `PEA_COLS; c++) begin
        row_sel[c] = sel[`PEA_ROW_SEL_W-1:0];
      end
      repeat (2) begin
        @(negedge clk);
        check_val("ready_o", 32'd1, {31'b0, ready});
        for (int c = 0; c < `PEA_COLS; c++) begin
          k_ext = zext(kmat[sel][c]);
          op = pe_op_e'((sel + c) % 4);
          check_val($sformatf("stream_o[%0d].valid", c), 32'd1, {31'b0, dut_out[c].valid});
          check_val($sformatf("stream_o[%0d].data", c), ref_op(op, k_ext, k_ext),
                    dut_out[c].data);
        end
        next_cycle();
      end
    end
    report_test("output select and ready", err_start);
  endtask

  initial begin
    void'($urandom(16225));
    cfg      = '0;
    row_sel  = '0;
    stream   = '0;
    chk_en   = '0;
    err_cnt  = 0;
    chk_cnt  = 0;
    test_cnt = 0;

    test_reset();
    test_single_ops();
    test_chain();
    test_accumulate();
    test_select_ready();

    $display("Tests run: %0d, checks: %0d, errors: %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+verilog
verilog/pea_pkg.sv
verilog/pe_acc_counter.sv
verilog/pe.sv
verilog/pea_array.sv
verilog/pea.sv
sim/tb_clk_gen.sv
sim/tb_pea.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the PE array testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_pea -Mdir "$BUILD_DIR" -f flist.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/Vtb_pea" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" "$LOG_FILE"; then
  exit 1
fi
if ! grep -q "Testbench passed" "$LOG_FILE"; then
  echo "No result line found in $LOG_FILE"
  exit 1
fi
exit 0
